//--- design/cmd_regs.sv
/* Wishbone classic register slave. Holds run, ptt, gain and threshold,
   reports the version and a saturating overflow count. */

`timescale 1ns/100ps

module cmd_regs (
  input  logic                     pi_tx_clk,
  input  logic                     reset,
  input  radio_cmd_pkg::wb_req_t   wb_req,
  input  logic                     overflow_event,
  output logic [31:0]              wb_dat_o,
  output logic                     wb_ack,
  output radio_cmd_pkg::radio_cfg_t cfg
);

  logic [15:0] ovf_cnt;
  logic        wr_en;

  // Write lands on the ack cycle, master still holds adr and dat
  assign wr_en = wb_ack & wb_req.we;

  // ------------------------------
  // Ack and register writes
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (reset) begin
      wb_ack  <= 1'b0;
      cfg     <= '0;
      ovf_cnt <= '0;
    end else begin
      // One ack per access, then low for a cycle
      wb_ack <= wb_req.cyc & wb_req.stb & ~wb_ack;
      if (wr_en) begin
        case (wb_req.adr)
          radio_cmd_pkg::ADDR_CONTROL: begin
            cfg.run <= wb_req.dat[0];
            cfg.ptt <= wb_req.dat[1];
          end
          radio_cmd_pkg::ADDR_TX_GAIN:   cfg.tx_gain   <= wb_req.dat[1:0];
          radio_cmd_pkg::ADDR_RX_THRESH: cfg.rx_thresh <= wb_req.dat[5:0];
          // Read-only and unknown addresses ignore writes
          default: ;
        endcase
      end
      // Saturating drop counter
      if (overflow_event && ovf_cnt != 16'hffff) begin
        ovf_cnt <= ovf_cnt + 16'd1;
      end
    end
  end

  // ------------------------------
  // Read mux, sampled by the master while ack is high
  // ------------------------------
  always_comb begin
    case (wb_req.adr)
      radio_cmd_pkg::ADDR_VERSION:
        wb_dat_o = {16'h0, radio_cmd_pkg::VERSION_MAJOR, radio_cmd_pkg::VERSION_MINOR};
      radio_cmd_pkg::ADDR_CONTROL:   wb_dat_o = {30'h0, cfg.ptt, cfg.run};
      radio_cmd_pkg::ADDR_TX_GAIN:   wb_dat_o = {30'h0, cfg.tx_gain};
      radio_cmd_pkg::ADDR_RX_THRESH: wb_dat_o = {26'h0, cfg.rx_thresh};
      radio_cmd_pkg::ADDR_STATUS:    wb_dat_o = {16'h0, ovf_cnt};
      default:                       wb_dat_o = '0;
    endcase
  end

  // Write data is taken on the ack cycle, so the request must not move before it
  a_req_held: assert property (@(posedge pi_tx_clk) disable iff (reset)
    wb_req.cyc && wb_req.stb && !wb_ack |=> $stable(wb_req));

endmodule

//--- design/iq_stream_pkg.sv
/* IQ sample and word types carried on the TX and RX streams.
   The TX word is 16-bit I/Q from the host, the RX word is 12-bit I/Q from the ADC. */

package iq_stream_pkg;

  // ------------------------------
  // Sample and word types
  // ------------------------------
  // One DAC/ADC sample, two's complement
  typedef logic [11:0] sample_t;

  // Host TX word, I in the upper half
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } iq_word_t;

  // RX word built from four ADC halves
  typedef struct packed {
    sample_t i;
    sample_t q;
  } rx_word_t;

  // ------------------------------
  // Nibble framing on the host bus
  // ------------------------------
  // Nibbles per TX word, 32 / 4
  localparam int TX_NIBBLES = 8;

  // Nibbles per RX word, 24 / 4
  localparam int RX_NIBBLES = 6;

  // Half samples per frame on the AD9866 port
  localparam int HALVES_PER_FRAME = 4;

endpackage

//--- design/radio_cmd_pkg.sv
/* Command side definitions: Wishbone register map, version and radio configuration.
   Shared by the register block, the modulator and the top level. */

package radio_cmd_pkg;

  // ------------------------------
  // Register map
  // ------------------------------
  typedef logic [3:0] reg_addr_t;

  localparam reg_addr_t ADDR_VERSION   = 4'd0;  // Read only
  localparam reg_addr_t ADDR_CONTROL   = 4'd1;  // Bit0 run, bit1 ptt
  localparam reg_addr_t ADDR_TX_GAIN   = 4'd2;  // Right shift 0..3
  localparam reg_addr_t ADDR_RX_THRESH = 4'd3;  // RX fill threshold
  localparam reg_addr_t ADDR_STATUS    = 4'd4;  // Read only, overflow count

  // Firmware version reported at ADDR_VERSION
  localparam logic [7:0] VERSION_MAJOR = 8'd69;
  localparam logic [7:0] VERSION_MINOR = 8'd3;

  // Radio configuration, 10 bits
  typedef struct packed {
    logic       run;
    logic       ptt;
    logic [1:0] tx_gain;
    logic [5:0] rx_thresh;
  } radio_cfg_t;

  // Master to slave Wishbone classic signals
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    reg_addr_t   adr;
    logic [31:0] dat;
  } wb_req_t;

endpackage

//--- design/radio_core.sv
/* Top level of the single-clock radio slice. Connects the Wishbone registers,
   the TX and RX stream paths, and raises the samples-ready flag for the host. */

`timescale 1ns/100ps

module radio_core #(
  parameter int TX_DEPTH = 16,
  parameter int RX_DEPTH = 32
) (
  input  logic                   pi_tx_clk,
  input  logic                   reset,
  // Wishbone
  input  radio_cmd_pkg::wb_req_t wb_req,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack,
  // Host TX nibbles
  input  logic [3:0]             pi_tx_data,
  input  logic                   pi_tx_valid,
  // AD9866
  input  logic [5:0]             rffe_ad9866_rx,
  input  logic                   rffe_ad9866_rxsync,
  output logic [5:0]             rffe_ad9866_tx,
  output logic                   rffe_ad9866_txsync,
  output logic                   rffe_ad9866_txquiet_n,
  // Host RX nibbles
  output logic [3:0]             pi_rx_data,
  output logic                   pi_rx_data_valid,
  output logic                   pi_rx_last,
  output logic                   pi_rx_samples
);

  radio_cmd_pkg::radio_cfg_t cfg;
  logic                      overflow_event;

  // TX stream
  iq_stream_pkg::iq_word_t   asm_word;
  logic                      asm_valid;
  logic                      asm_ready;
  logic                      tx_dropped;
  iq_stream_pkg::iq_word_t   txf_word;
  logic                      txf_valid;
  logic                      txf_ready;

  // RX stream
  iq_stream_pkg::rx_word_t   frm_word;
  logic                      frm_valid;
  logic                      frm_ready;
  logic                      rx_dropped;
  iq_stream_pkg::rx_word_t   rxf_word;
  logic                      rxf_valid;
  logic                      rxf_ready;
  logic [$clog2(RX_DEPTH+1)-1:0] rx_level;

  // Either path losing a word counts as overflow
  assign overflow_event = tx_dropped | rx_dropped;

  // ------------------------------
  // Command registers
  // ------------------------------
  cmd_regs u_cmd_regs (
    .pi_tx_clk, .reset, .wb_req, .overflow_event, .wb_dat_o, .wb_ack, .cfg
  );

  // ------------------------------
  // TX path, host to DAC
  // ------------------------------
  tx_nibble_assembler u_tx_asm (
    .pi_tx_clk, .reset, .pi_tx_data, .pi_tx_valid,
    .word_ready(asm_ready), .word(asm_word), .word_valid(asm_valid),
    .word_dropped(tx_dropped)
  );

  stream_fifo #(.payload_t(iq_stream_pkg::iq_word_t), .DEPTH(TX_DEPTH)) u_tx_fifo (
    .pi_tx_clk, .reset,
    .in_data(asm_word), .in_valid(asm_valid), .in_ready(asm_ready),
    .out_data(txf_word), .out_valid(txf_valid), .out_ready(txf_ready),
    .level()
  );

  tx_modulator u_tx_mod (
    .pi_tx_clk, .reset, .cfg,
    .word(txf_word), .word_valid(txf_valid), .word_ready(txf_ready),
    .rffe_ad9866_tx, .rffe_ad9866_txsync, .rffe_ad9866_txquiet_n
  );

  // ------------------------------
  // RX path, ADC to host
  // ------------------------------
  rx_framer u_rx_frm (
    .pi_tx_clk, .reset, .rffe_ad9866_rx, .rffe_ad9866_rxsync,
    .word_ready(frm_ready), .word(frm_word), .word_valid(frm_valid),
    .word_dropped(rx_dropped)
  );

  stream_fifo #(.payload_t(iq_stream_pkg::rx_word_t), .DEPTH(RX_DEPTH)) u_rx_fifo (
    .pi_tx_clk, .reset,
    .in_data(frm_word), .in_valid(frm_valid), .in_ready(frm_ready),
    .out_data(rxf_word), .out_valid(rxf_valid), .out_ready(rxf_ready),
    .level(rx_level)
  );

  rx_nibble_serializer u_rx_ser (
    .pi_tx_clk, .reset,
    .word(rxf_word), .word_valid(rxf_valid), .word_ready(rxf_ready),
    .pi_rx_data, .pi_rx_data_valid, .pi_rx_last
  );

  // Samples ready once the backlog passes the threshold, one cycle late
  always_ff @(posedge pi_tx_clk) begin
    if (reset) begin
      pi_rx_samples <= 1'b0;
    end else begin
      pi_rx_samples <= 32'(rx_level) > 32'(cfg.rx_thresh);
    end
  end

endmodule

//--- design/rx_framer.sv
/* Joins four 6-bit AD9866 receive halves into one 24-bit RX IQ word.
   rxsync marks I high and realigns the frame; a word refused by the FIFO is dropped. */

`timescale 1ns/100ps

module rx_framer (
  input  logic                    pi_tx_clk,
  input  logic                    reset,
  input  logic [5:0]              rffe_ad9866_rx,
  input  logic                    rffe_ad9866_rxsync,
  input  logic                    word_ready,
  output iq_stream_pkg::rx_word_t word,
  output logic                    word_valid,
  output logic                    word_dropped
);

  // 0 waits for sync, 1..3 expect I low, Q high, Q low
  logic [1:0]  phase;
  logic [17:0] acc;
  logic        q_low;

  assign q_low = !rffe_ad9866_rxsync &&
                 (phase == 2'(iq_stream_pkg::HALVES_PER_FRAME - 1));

  // ------------------------------
  // Phase tracking
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (reset) begin
      phase      <= 2'd0;
      word_valid <= 1'b0;
    end else begin
      // Word offered the cycle after Q low
      word_valid <= q_low;
      if (rffe_ad9866_rxsync) begin
        phase <= 2'd1;
      end else if (phase != 2'd0) begin
        phase <= phase + 2'd1;  // 3 wraps back to idle
      end
    end
  end

  // ------------------------------
  // Half accumulation
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    acc <= {acc[11:0], rffe_ad9866_rx};
    if (q_low) begin
      word <= iq_stream_pkg::rx_word_t'({acc, rffe_ad9866_rx});
    end
  end

  // Single-cycle offer, so a full FIFO loses the word
  assign word_dropped = word_valid & ~word_ready;

endmodule

//--- design/rx_nibble_serializer.sv
/* Sends RX words to the host as six nibbles, I high first, with last on the sixth.
   The next word is popped on the last nibble so words run back to back. */

`timescale 1ns/100ps

module rx_nibble_serializer (
  input  logic                    pi_tx_clk,
  input  logic                    reset,
  input  iq_stream_pkg::rx_word_t word,
  input  logic                    word_valid,
  output logic                    word_ready,
  output logic [3:0]              pi_rx_data,
  output logic                    pi_rx_data_valid,
  output logic                    pi_rx_last
);

  logic [2:0]  nib_cnt;
  logic        busy;
  logic        end_nib;
  logic [23:0] shift;

  assign end_nib    = busy && (nib_cnt == 3'(iq_stream_pkg::RX_NIBBLES - 1));
  // Idle or finishing, either way room for the next word
  assign word_ready = !busy || end_nib;

  // ------------------------------
  // Nibble counter
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (reset) begin
      busy    <= 1'b0;
      nib_cnt <= '0;
    end else if (word_valid && word_ready) begin
      busy    <= 1'b1;
      nib_cnt <= '0;
    end else if (busy) begin
      if (end_nib) begin
        busy    <= 1'b0;
        nib_cnt <= '0;
      end else begin
        nib_cnt <= nib_cnt + 3'd1;
      end
    end
  end

  // Held word shifts up one nibble per cycle
  always_ff @(posedge pi_tx_clk) begin
    if (word_valid && word_ready) begin
      shift <= word;
    end else if (busy) begin
      shift <= {shift[19:0], 4'h0};
    end
  end

  // ------------------------------
  // Host outputs
  // ------------------------------
  assign pi_rx_data       = shift[23:20];
  assign pi_rx_data_valid = busy;
  assign pi_rx_last       = end_nib;

endmodule

//--- design/stream_fifo.sv
/* Synchronous FIFO with a registered output stage and valid/ready on both sides.
   Payload type and depth come from the instantiating module; level counts all words held. */

`timescale 1ns/100ps

module stream_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic                           pi_tx_clk,
  input  logic                           reset,
  input  payload_t                       in_data,
  input  logic                           in_valid,
  output logic                           in_ready,
  output payload_t                       out_data,
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [$clog2(DEPTH+1)-1:0]     level
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   cnt;      // Words in memory, not in the output stage
  logic            push;
  logic            pop;
  logic            load;     // Output stage takes a new word
  logic            mem_wr;
  logic            mem_rd;

  assign level    = cnt + CW'(out_valid);
  assign in_ready = level < CW'(DEPTH);
  assign push     = in_valid & in_ready;
  assign pop      = out_valid & out_ready;
  assign load     = ~out_valid | pop;
  // Empty memory with a free output stage bypasses straight through
  assign mem_rd   = load & (cnt != '0);
  assign mem_wr   = push & ~(load & (cnt == '0));

  // ------------------------------
  // Pointers and counts
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      cnt       <= '0;
      out_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (mem_wr && !mem_rd) begin
        cnt <= cnt + 1'b1;
      end else if (!mem_wr && mem_rd) begin
        cnt <= cnt - 1'b1;
      end
      if (load) begin
        out_valid <= (cnt != '0) | push;
      end
    end
  end

  // ------------------------------
  // Storage and output register
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= in_data;
    end
    if (load) begin
      out_data <= (cnt != '0) ? mem[rd_ptr] : in_data;
    end
  end

  // Level moves by exactly one per accepted push or pop, bypass included
  a_level_track: assert property (@(posedge pi_tx_clk) disable iff (reset)
    1'b1 |=> level == $past(level) + CW'($past(push)) - CW'($past(pop)));

  // A word left in memory always has the output stage filled ahead of it
  a_no_stranded: assert property (@(posedge pi_tx_clk) disable iff (reset)
    cnt != '0 |-> out_valid);

endmodule

//--- design/tx_modulator.sv
/* Drains TX words while run and ptt are set, scales each sample by the gain shift
   and sends I high, I low, Q high, Q low halves on the AD9866 transmit port. */

`timescale 1ns/100ps

module tx_modulator (
  input  logic                       pi_tx_clk,
  input  logic                       reset,
  input  radio_cmd_pkg::radio_cfg_t  cfg,
  input  iq_stream_pkg::iq_word_t    word,
  input  logic                       word_valid,
  output logic                       word_ready,
  output logic [5:0]                 rffe_ad9866_tx,
  output logic                       rffe_ad9866_txsync,
  output logic                       rffe_ad9866_txquiet_n
);

  logic                    en;
  logic [1:0]              phase;    // Next half to send
  iq_stream_pkg::sample_t  i_smp;
  iq_stream_pkg::sample_t  q_smp;
  iq_stream_pkg::sample_t  i_hold;
  iq_stream_pkg::sample_t  q_hold;

  // Upper 12 bits, arithmetic shift by the gain setting
  function automatic iq_stream_pkg::sample_t scale(input logic [15:0] field,
                                                   input logic [1:0]  gain);
    scale = iq_stream_pkg::sample_t'($signed(field[15:4]) >>> gain);
  endfunction

  assign en         = cfg.run & cfg.ptt;
  assign word_ready = en && (phase == 2'd0);
  assign i_smp      = scale(word.i, cfg.tx_gain);
  assign q_smp      = scale(word.q, cfg.tx_gain);

  // ------------------------------
  // Frame sequencer
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (reset) begin
      phase                 <= 2'd0;
      rffe_ad9866_tx        <= '0;
      rffe_ad9866_txsync    <= 1'b0;
      rffe_ad9866_txquiet_n <= 1'b0;
    end else begin
      rffe_ad9866_txquiet_n <= en;
      rffe_ad9866_txsync    <= 1'b0;
      rffe_ad9866_tx        <= '0;
      if (!en) begin
        // Quiet, FIFO left untouched
        phase <= 2'd0;
      end else begin
        case (phase)
          2'd0: begin
            // New frame starts with I high and sync
            if (word_valid) begin
              rffe_ad9866_tx     <= i_smp[11:6];
              rffe_ad9866_txsync <= 1'b1;
              phase              <= 2'd1;
            end
          end
          2'd1: begin
            rffe_ad9866_tx <= i_hold[5:0];
            phase          <= 2'd2;
          end
          2'd2: begin
            rffe_ad9866_tx <= q_hold[11:6];
            phase          <= 2'd3;
          end
          default: begin
            rffe_ad9866_tx <= q_hold[5:0];
            phase          <= 2'd0;
          end
        endcase
      end
    end
  end

  // Scaled samples kept for the rest of the frame
  always_ff @(posedge pi_tx_clk) begin
    if (word_valid && word_ready) begin
      i_hold <= i_smp;
      q_hold <= q_smp;
    end
  end

endmodule

//--- design/tx_nibble_assembler.sv
/* Packs eight host nibbles, MSB first, into one TX IQ word.
   A word that finds the FIFO full is dropped and flagged. */

`timescale 1ns/100ps

module tx_nibble_assembler (
  input  logic                   pi_tx_clk,
  input  logic                   reset,
  input  logic [3:0]             pi_tx_data,
  input  logic                   pi_tx_valid,
  input  logic                   word_ready,
  output iq_stream_pkg::iq_word_t word,
  output logic                   word_valid,
  output logic                   word_dropped
);

  logic [2:0]  nib_cnt;
  logic [27:0] shift;
  logic        last_nib;

  // Eighth nibble of the word on the bus
  assign last_nib = pi_tx_valid && (nib_cnt == 3'(iq_stream_pkg::TX_NIBBLES - 1));

  // ------------------------------
  // Nibble counter and word strobe
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (reset) begin
      nib_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      // Offered for exactly one cycle
      word_valid <= last_nib;
      if (pi_tx_valid) begin
        nib_cnt <= nib_cnt + 3'd1;  // Wraps after the eighth
      end
    end
  end

  // ------------------------------
  // Payload shift
  // ------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (pi_tx_valid) begin
      shift <= {shift[23:0], pi_tx_data};
    end
    // I high byte ends up on top
    if (last_nib) begin
      word <= iq_stream_pkg::iq_word_t'({shift, pi_tx_data});
    end
  end

  // No backpressure to the host, so a refused word is lost
  assign word_dropped = word_valid & ~word_ready;

endmodule

//--- filelist.f
design/radio_cmd_pkg.sv
design/iq_stream_pkg.sv
design/cmd_regs.sv
design/tx_nibble_assembler.sv
design/stream_fifo.sv
design/tx_modulator.sv
design/rx_framer.sv
design/rx_nibble_serializer.sv
design/radio_core.sv
testbench/tb_clock_gen.sv
testbench/tb_radio_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the radio_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_radio_core \
  --Mdir obj_dir -o sim_radio_core \
  -f filelist.f

./obj_dir/sim_radio_core | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation passed"

//--- testbench/tb_clock_gen.sv
/* Clock and reset source for the radio testbench.
   100 ns clock, synchronous reset held high for the first 10 rising edges. */

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 10
) (
  output logic pi_tx_clk,
  output logic reset
);

  // 50 ns half period
  initial begin
    pi_tx_clk = 1'b0;
    forever #50 pi_tx_clk = ~pi_tx_clk;
  end

  // Released on a rising edge, DUT sees it low one edge later
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge pi_tx_clk);
    reset <= 1'b0;
  end

endmodule

//--- testbench/tb_radio_core.sv
/* Testbench for radio_core. Drives Wishbone, host TX nibbles and AD9866 RX halves,
   checks TX halves, RX nibbles and the samples-ready flag against scoreboard models. */

`timescale 1ns/100ps

module tb_radio_core;

  localparam int TX_DEPTH   = 16;
  localparam int RX_DEPTH   = 32;
  localparam int WAIT_LIMIT = 2000;

  logic                   pi_tx_clk;
  logic                   reset;
  radio_cmd_pkg::wb_req_t wb_req;
  logic [31:0]            wb_dat_o;
  logic                   wb_ack;
  logic [3:0]             pi_tx_data;
  logic                   pi_tx_valid;
  logic [5:0]             rffe_ad9866_rx;
  logic                   rffe_ad9866_rxsync;
  logic [5:0]             rffe_ad9866_tx;
  logic                   rffe_ad9866_txsync;
  logic                   rffe_ad9866_txquiet_n;
  logic [3:0]             pi_rx_data;
  logic                   pi_rx_data_valid;
  logic                   pi_rx_last;
  logic                   pi_rx_samples;

  // Scoreboard state
  logic [31:0] tx_word_q[$];
  logic [3:0]  rx_nib_q[$];
  logic [5:0]  tx_halves[4];
  logic [31:0] tx_w;
  logic [11:0] tx_i_s;
  logic [11:0] tx_q_s;
  int          tx_pos;
  int          rx_nib_idx;
  int          rx_level_model;
  logic [2:0]  rx_end_hist;
  int          tx_gain_model = 0;
  int          rx_thresh_model = 0;
  int          samples_high_cnt = 0;
  logic        rx_word_end;
  logic        tx_hold;
  logic [31:0] rng;

  int check_errors  = 0;
  int assert_errors = 0;
  int timeouts      = 0;

  tb_clock_gen u_clk_gen (.pi_tx_clk, .reset);

  radio_core #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) u_dut (
    .pi_tx_clk, .reset, .wb_req, .wb_dat_o, .wb_ack,
    .pi_tx_data, .pi_tx_valid, .rffe_ad9866_rx, .rffe_ad9866_rxsync,
    .rffe_ad9866_tx, .rffe_ad9866_txsync, .rffe_ad9866_txquiet_n,
    .pi_rx_data, .pi_rx_data_valid, .pi_rx_last, .pi_rx_samples
  );

  // ------------------------------
  // Checking helpers
  // ------------------------------
  function automatic void check_value(input string name, input logic [31:0] got,
                                      input logic [31:0] exp);
    assert (got == exp) else begin
      check_errors++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endfunction

  function automatic void report_error(input string what);
    check_errors++;
    $display("Error: %s", what);
  endfunction

  function automatic void note_timeout(input string what);
    timeouts++;
    $display("Timeout while waiting for %s", what);
  endfunction

  // 32-bit xorshift
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Top 12 bits of the field, sign copied in once per gain step
  function automatic logic [11:0] scale_sample(input logic [15:0] field, input int gain);
    logic [11:0] s;
    s = field[15:4];
    for (int k = 0; k < gain; k++) begin
      s = {s[11], s[11:1]};
    end
    return s;
  endfunction

  // ------------------------------
  // Wishbone master
  // ------------------------------
  task automatic reg_access(input logic we, input radio_cmd_pkg::reg_addr_t adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    radio_cmd_pkg::wb_req_t req;
    int n;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    rdat = '0;
    n = 0;
    @(posedge pi_tx_clk);
    wb_req <= req;
    @(negedge pi_tx_clk);
    while (!wb_ack && n < WAIT_LIMIT) begin
      @(negedge pi_tx_clk);
      n++;
    end
    // Read data only valid with ack
    if (wb_ack) begin
      rdat = wb_dat_o;
    end else begin
      note_timeout("Wishbone ack");
    end
    @(posedge pi_tx_clk);
    wb_req <= '0;
  endtask

  task automatic reg_write(input radio_cmd_pkg::reg_addr_t adr, input logic [31:0] dat);
    logic [31:0] unused;
    reg_access(1'b1, adr, dat, unused);
  endtask

  task automatic reg_check(input string name, input radio_cmd_pkg::reg_addr_t adr,
                           input logic [31:0] exp);
    logic [31:0] rdat;
    reg_access(1'b0, adr, '0, rdat);
    check_value(name, rdat, exp);
  endtask

  // ------------------------------
  // Stream drivers and waits
  // ------------------------------
  // Eight nibbles, MSB first, then one idle cycle
  task automatic send_tx_word(input logic [31:0] w, input logic keep);
    if (keep) begin
      tx_word_q.push_back(w);
    end
    for (int n = 7; n >= 0; n--) begin
      @(posedge pi_tx_clk);
      pi_tx_data  <= w[n*4 +: 4];
      pi_tx_valid <= 1'b1;
    end
    @(posedge pi_tx_clk);
    pi_tx_valid <= 1'b0;
  endtask

  // I high with sync, then I low, Q high, Q low
  task automatic send_rx_word(input logic [23:0] w);
    for (int k = 5; k >= 0; k--) begin
      rx_nib_q.push_back(w[k*4 +: 4]);
    end
    for (int k = 0; k < 4; k++) begin
      @(posedge pi_tx_clk);
      rffe_ad9866_rx     <= w[23 - 6*k -: 6];
      rffe_ad9866_rxsync <= (k == 0);
      rx_word_end        <= (k == 3);
    end
  endtask

  task automatic rx_idle(input int cycles);
    repeat (cycles) begin
      @(posedge pi_tx_clk);
      rffe_ad9866_rx     <= '0;
      rffe_ad9866_rxsync <= 1'b0;
      rx_word_end        <= 1'b0;
    end
  endtask

  task automatic wait_tx_drained();
    int n;
    n = 0;
    while ((tx_word_q.size() != 0 || tx_pos != 0) && n < WAIT_LIMIT) begin
      @(negedge pi_tx_clk);
      n++;
    end
    if (tx_word_q.size() != 0 || tx_pos != 0) note_timeout("TX words on the DAC port");
  endtask

  task automatic wait_rx_drained();
    int n;
    n = 0;
    while ((rx_nib_q.size() != 0 || rx_nib_idx != 0) && n < WAIT_LIMIT) begin
      @(negedge pi_tx_clk);
      n++;
    end
    if (rx_nib_q.size() != 0 || rx_nib_idx != 0) note_timeout("RX nibbles to the host");
  endtask

  task automatic wait_quiet();
    int n;
    n = 0;
    while (rffe_ad9866_txquiet_n && n < WAIT_LIMIT) begin
      @(negedge pi_tx_clk);
      n++;
    end
    if (rffe_ad9866_txquiet_n) note_timeout("txquiet_n to drop");
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (reset && n < WAIT_LIMIT) begin
      @(negedge pi_tx_clk);
      n++;
    end
    if (reset) note_timeout("reset release");
  endtask

  // ------------------------------
  // TX monitor
  // ------------------------------
  always @(negedge pi_tx_clk) begin
    if (reset) begin
      tx_pos = 0;
    end else if (tx_pos != 0) begin
      // Rest of the frame, one half per cycle
      check_value("rffe_ad9866_tx", rffe_ad9866_tx, tx_halves[tx_pos]);
      check_value("rffe_ad9866_txsync", rffe_ad9866_txsync, 0);
      tx_pos = (tx_pos + 1) % 4;
    end else if (rffe_ad9866_txsync) begin
      if (tx_word_q.size() == 0) begin
        report_error("TX frame started with no word pending");
      end else begin
        tx_w   = tx_word_q.pop_front();
        tx_i_s = scale_sample(tx_w[31:16], tx_gain_model);
        tx_q_s = scale_sample(tx_w[15:0], tx_gain_model);
        tx_halves[0] = tx_i_s[11:6];
        tx_halves[1] = tx_i_s[5:0];
        tx_halves[2] = tx_q_s[11:6];
        tx_halves[3] = tx_q_s[5:0];
        check_value("rffe_ad9866_tx", rffe_ad9866_tx, tx_halves[0]);
        tx_pos = 1;
      end
    end else begin
      // Idle between frames
      check_value("rffe_ad9866_tx", rffe_ad9866_tx, 0);
    end
  end

  // ------------------------------
  // RX monitor and level model
  // ------------------------------
  always @(negedge pi_tx_clk) begin
    if (reset) begin
      rx_nib_idx     = 0;
      rx_level_model = 0;
      rx_end_hist    = '0;
    end else begin
      // Flag reflects the level of the previous cycle
      check_value("pi_rx_samples", pi_rx_samples, rx_level_model > rx_thresh_model);
      if (pi_rx_samples) samples_high_cnt++;
      // Q low driven two edges ago lands in the FIFO now
      rx_end_hist = {rx_end_hist[1:0], rx_word_end};
      if (rx_end_hist[2]) rx_level_model++;
      if (pi_rx_data_valid) begin
        // First nibble means a word left the FIFO
        if (rx_nib_idx == 0) rx_level_model--;
        if (rx_nib_q.size() == 0) begin
          report_error("Nibble on pi_rx_data with no RX word pending");
        end else begin
          check_value("pi_rx_data", pi_rx_data, rx_nib_q.pop_front());
        end
        check_value("pi_rx_last", pi_rx_last, rx_nib_idx == 5);
        rx_nib_idx = (rx_nib_idx + 1) % 6;
      end
    end
  end

  // ------------------------------
  // Protocol assertions
  // ------------------------------
  a_quiet_zero: assert property (@(posedge pi_tx_clk) disable iff (reset)
    !rffe_ad9866_txquiet_n |-> (rffe_ad9866_tx == 6'd0) && !rffe_ad9866_txsync)
    else begin
      assert_errors++;
      $display("[FAIL] rffe_ad9866_tx 0x%0h while txquiet_n low", $sampled(rffe_ad9866_tx));
    end

  a_hold_quiet: assert property (@(posedge pi_tx_clk) disable iff (reset)
    tx_hold |-> !rffe_ad9866_txquiet_n)
    else begin
      assert_errors++;
      $display("[FAIL] rffe_ad9866_txquiet_n 0x1 expected 0x0 with ptt clear");
    end

  a_last_in_word: assert property (@(posedge pi_tx_clk) disable iff (reset)
    pi_rx_last |-> pi_rx_data_valid)
    else begin
      assert_errors++;
      $display("[FAIL] pi_rx_data_valid 0x0 expected 0x1 with pi_rx_last");
    end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [31:0] w;
    int          samples_before;
    wb_req             = '0;
    pi_tx_data         = '0;
    pi_tx_valid        = 1'b0;
    rffe_ad9866_rx     = '0;
    rffe_ad9866_rxsync = 1'b0;
    rx_word_end        = 1'b0;
    tx_hold            = 1'b0;
    rng                = 32'd71349;
    wait_reset_release();

    // Register map, version 69.3
    reg_check("wb_dat_o (version)", radio_cmd_pkg::ADDR_VERSION, {16'h0, 8'd69, 8'd3});
    reg_write(radio_cmd_pkg::ADDR_CONTROL, 32'h3);
    reg_check("wb_dat_o (control)", radio_cmd_pkg::ADDR_CONTROL, 32'h3);
    reg_write(radio_cmd_pkg::ADDR_TX_GAIN, 32'h2);
    reg_check("wb_dat_o (tx_gain)", radio_cmd_pkg::ADDR_TX_GAIN, 32'h2);
    reg_write(radio_cmd_pkg::ADDR_RX_THRESH, 32'h2a);
    rx_thresh_model = 32'h2a;
    reg_check("wb_dat_o (rx_thresh)", radio_cmd_pkg::ADDR_RX_THRESH, 32'h2a);
    reg_write(radio_cmd_pkg::ADDR_VERSION, 32'hffff_ffff);
    reg_check("wb_dat_o (version)", radio_cmd_pkg::ADDR_VERSION, {16'h0, 8'd69, 8'd3});
    reg_check("wb_dat_o (status)", radio_cmd_pkg::ADDR_STATUS, 32'h0);

    // TX path at every gain, run and ptt already set
    for (int g = 0; g < 4; g++) begin
      reg_write(radio_cmd_pkg::ADDR_TX_GAIN, g);
      tx_gain_model = g;
      repeat (6) send_tx_word(next_rand(), 1'b1);
      wait_tx_drained();
    end

    // TX hold with ptt clear, release afterwards
    reg_write(radio_cmd_pkg::ADDR_CONTROL, 32'h1);
    wait_quiet();
    @(posedge pi_tx_clk);
    tx_hold <= 1'b1;
    repeat (6) send_tx_word(next_rand(), 1'b1);
    @(posedge pi_tx_clk);
    tx_hold <= 1'b0;
    reg_write(radio_cmd_pkg::ADDR_CONTROL, 32'h3);
    wait_tx_drained();

    // Overflow, the last three words find the FIFO full
    reg_write(radio_cmd_pkg::ADDR_CONTROL, 32'h1);
    wait_quiet();
    for (int n = 0; n < TX_DEPTH + 3; n++) begin
      send_tx_word(next_rand(), n < TX_DEPTH);
    end
    reg_check("wb_dat_o (status)", radio_cmd_pkg::ADDR_STATUS, 32'h3);
    reg_write(radio_cmd_pkg::ADDR_CONTROL, 32'h3);
    wait_tx_drained();

    // RX path, spaced words
    reg_write(radio_cmd_pkg::ADDR_RX_THRESH, 32'h0);
    rx_thresh_model = 0;
    repeat (10) begin
      w = next_rand();
      send_rx_word(w[23:0]);
      rx_idle(4);
    end
    wait_rx_drained();

    // Back to back RX words outrun the host side
    reg_write(radio_cmd_pkg::ADDR_RX_THRESH, 32'h5);
    rx_thresh_model = 5;
    samples_before = samples_high_cnt;
    repeat (30) begin
      w = next_rand();
      send_rx_word(w[23:0]);
    end
    rx_idle(1);
    wait_rx_drained();
    if (samples_high_cnt == samples_before) begin
      report_error("pi_rx_samples never rose during the RX backlog");
    end

    $display("Errors: %0d check, %0d assertion, %0d timeout",
             check_errors, assert_errors, timeouts);
    if (check_errors + assert_errors + timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
